// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS = --lint-only --timing --timescale 1ns/1ps
TOP       = tb_bios_loader
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bios_loader_top.sv ====
// BIOS loader top; the host must keep beat_i stable while beat_valid_i waits for ready
module bios_loader_top
	import loader_pkg::*;
#(
	// strobe low time in clk_chipset cycles
	parameter int WRITE_PULSE_CYCLES = 21,
	// full write cycle, strobe plus recovery
	parameter int WRITE_CYCLE_CYCLES = 41
) (
	input  logic        clk_chipset,
	input  logic        reset,
	input  logic        download_i,
	input  logic        sdram_ready_i,
	input  logic        bus_granted_i,
	input  logic        beat_valid_i,
	input  ioctl_beat_t beat_i,
	output logic        beat_ready_o,
	output logic        bus_request_o,
	output logic        bios_protect_o,
	output bus_write_t  bus_write_o,
	output logic        mem_write_n_o
);

	// decode to grant
	logic       dec_valid;
	logic       dec_ready;
	bus_write_t dec_write;

	// grant to timer
	logic       grt_valid;
	logic       grt_ready;
	bus_write_t grt_write;

	//////////////////////////////////////////////////////////////////////////
	// three stage chain
	//////////////////////////////////////////////////////////////////////////

	rom_select_decode u_rom_select_decode (
		.clk_chipset  (clk_chipset),
		.reset        (reset),
		.beat_valid_i (beat_valid_i),
		.beat_i       (beat_i),
		.out_ready_i  (dec_ready),
		.beat_ready_o (beat_ready_o),
		.out_valid_o  (dec_valid),
		.out_o        (dec_write)
	);

	bus_grant_gate u_bus_grant_gate (
		.clk_chipset    (clk_chipset),
		.reset          (reset),
		.download_i     (download_i),
		.sdram_ready_i  (sdram_ready_i),
		.bus_granted_i  (bus_granted_i),
		.in_valid_i     (dec_valid),
		.in_i           (dec_write),
		.out_ready_i    (grt_ready),
		.in_ready_o     (dec_ready),
		.out_valid_o    (grt_valid),
		.out_o          (grt_write),
		.bus_request_o  (bus_request_o),
		.bios_protect_o (bios_protect_o)
	);

	write_strobe_timer #(
		.WRITE_PULSE_CYCLES (WRITE_PULSE_CYCLES),
		.WRITE_CYCLE_CYCLES (WRITE_CYCLE_CYCLES)
	) u_write_strobe_timer (
		.clk_chipset   (clk_chipset),
		.reset         (reset),
		.in_valid_i    (grt_valid),
		.in_i          (grt_write),
		.in_ready_o    (grt_ready),
		.bus_write_o   (bus_write_o),
		.mem_write_n_o (mem_write_n_o)
	);

endmodule

// ==== bus_grant_gate.sv ====
// bus grant stage; held bytes stay upstream until the CPU side grants the bus
module bus_grant_gate
	import loader_pkg::*;
(
	input  logic       clk_chipset,
	input  logic       reset,
	input  logic       download_i,
	input  logic       sdram_ready_i,
	input  logic       bus_granted_i,
	input  logic       in_valid_i,
	input  bus_write_t in_i,
	input  logic       out_ready_i,
	output logic       in_ready_o,
	output logic       out_valid_o,
	output bus_write_t out_o,
	output logic       bus_request_o,
	output logic       bios_protect_o
);

	logic bus_request_q;
	logic protect_q;
	logic pass_en;

	//////////////////////////////////////////////////////////////////////////
	// request and protect
	//////////////////////////////////////////////////////////////////////////

	// ask for the bus once a download runs and SDRAM is up
	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset)
			bus_request_q <= 1'b0;
		else
			bus_request_q <= download_i & sdram_ready_i;
	end

	// bus is ours only while both sides agree
	assign pass_en = bus_request_q & bus_granted_i;

	// protect drops one cycle into a grant
	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset)
			protect_q <= 1'b1;
		else
			protect_q <= ~pass_en;
	end

	// and rises again at once when the grant goes away
	assign bios_protect_o = protect_q | ~pass_en;
	assign bus_request_o  = bus_request_q;

	//////////////////////////////////////////////////////////////////////////
	// handshake gating
	//////////////////////////////////////////////////////////////////////////

	// no grant stalls both sides, the byte stays in the decode register
	assign out_valid_o = in_valid_i & pass_en;
	assign in_ready_o  = out_ready_i & pass_en;
	assign out_o       = in_i;

endmodule

// ==== loader_pkg.sv ====
// shared loader types; 20-bit bus only, image indices are compared as full 8-bit values
package loader_pkg;

	//////////////////////////////////////////////////////////////////////////
	// bus geometry and image windows
	//////////////////////////////////////////////////////////////////////////

	// system bus is the 8088 one megabyte space
	localparam int BUS_ADDR_W = 20;

	// image index values sent by the host
	localparam logic [7:0] IMG_PCXT  = 8'd1;
	localparam logic [7:0] IMG_TANDY = 8'd2;
	localparam logic [7:0] IMG_XTIDE = 8'd3;

	// 64 KiB system BIOS window, shared by PCXT and Tandy images
	localparam logic [BUS_ADDR_W-1:0] BIOS_BASE = 20'hF0000;

	// 16 KiB option ROM window for XT-IDE
	localparam logic [BUS_ADDR_W-1:0] XTIDE_BASE = 20'hEC000;

	//////////////////////////////////////////////////////////////////////////
	// stream and bus payloads
	//////////////////////////////////////////////////////////////////////////

	// one byte from the host download stream
	typedef struct packed {
		logic [7:0]  index;
		// byte position inside the image file
		logic [24:0] offset;
		logic [7:0]  data;
	} ioctl_beat_t;

	// one byte write on the system bus
	typedef struct packed {
		logic [BUS_ADDR_W-1:0] addr;
		logic [7:0]            data;
		// set when the byte belongs to the Tandy BIOS image
		logic                  tandy;
	} bus_write_t;

endpackage

// ==== project.f ====
loader_pkg.sv
rom_select_decode.sv
bus_grant_gate.sv
write_strobe_timer.sv
bios_loader_top.sv
tb_bios_loader.sv

// ==== rom_select_decode.sv ====
// decode stage; bytes outside every ROM window are accepted and silently dropped
module rom_select_decode
	import loader_pkg::*;
(
	input  logic        clk_chipset,
	input  logic        reset,
	input  logic        beat_valid_i,
	input  ioctl_beat_t beat_i,
	input  logic        out_ready_i,
	output logic        beat_ready_o,
	output logic        out_valid_o,
	output bus_write_t  out_o
);

	logic                  sel_bios;
	logic                  sel_xtide;
	logic                  hit;
	logic                  accept;
	logic [BUS_ADDR_W-1:0] map_addr;
	logic                  out_valid_q;
	bus_write_t            out_q;

	// window select from the image index
	always_comb begin
		// BIOS images must fit in 64 KiB
		sel_bios  = ((beat_i.index == IMG_PCXT) || (beat_i.index == IMG_TANDY)) &&
		            (beat_i.offset[24:16] == '0);
		// option ROM wraps inside its 16 KiB window
		sel_xtide = (beat_i.index == IMG_XTIDE);
		hit       = sel_bios | sel_xtide;
		if (sel_xtide)
			map_addr = XTIDE_BASE + BUS_ADDR_W'(beat_i.offset[13:0]);
		else
			map_addr = BIOS_BASE + BUS_ADDR_W'(beat_i.offset[15:0]);
	end

	// free slot, or the held byte leaves this cycle
	assign beat_ready_o = ~out_valid_q | out_ready_i;
	assign accept       = beat_valid_i & beat_ready_o;

	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset)
			out_valid_q <= 1'b0;
		else if (accept)
			out_valid_q <= hit;
		else if (out_ready_i)
			out_valid_q <= 1'b0;
	end

	// payload only loads on a window hit
	always_ff @(posedge clk_chipset) begin
		if (accept && hit) begin
			out_q.addr  <= map_addr;
			out_q.data  <= beat_i.data;
			out_q.tandy <= (beat_i.index == IMG_TANDY);
		end
	end

	assign out_valid_o = out_valid_q;
	assign out_o       = out_q;

endmodule

// ==== tb_bios_loader.sv ====
// directed testbench; assumes the default 21/41 strobe timing and checks writes in arrival order
module tb_bios_loader
	import loader_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PULSE_CYCLES  = 21;
	localparam int CYCLE_CYCLES  = 41;
	localparam int READY_TIMEOUT = 300;

	logic        clk_chipset;
	logic        reset;
	logic        download_i;
	logic        sdram_ready_i;
	logic        bus_granted_i;
	logic        beat_valid_i;
	ioctl_beat_t beat_i;
	logic        beat_ready_o;
	logic        bus_request_o;
	logic        bios_protect_o;
	bus_write_t  bus_write_o;
	logic        mem_write_n_o;

	int         seed;
	int         errors;
	int         checks;
	int         test_start;
	// expected and observed writes, in order
	bus_write_t exp_q[$];
	bus_write_t obs_q[$];
	// strobe measurements, in negedge cycles
	int         cycle;
	int         last_fall;
	int         low_run;
	int         low_min;
	int         low_max;
	int         gap_min;
	logic       write_n_prev;

	bios_loader_top #(
		.WRITE_PULSE_CYCLES (PULSE_CYCLES),
		.WRITE_CYCLE_CYCLES (CYCLE_CYCLES)
	) u_bios_loader_top (
		.clk_chipset    (clk_chipset),
		.reset          (reset),
		.download_i     (download_i),
		.sdram_ready_i  (sdram_ready_i),
		.bus_granted_i  (bus_granted_i),
		.beat_valid_i   (beat_valid_i),
		.beat_i         (beat_i),
		.beat_ready_o   (beat_ready_o),
		.bus_request_o  (bus_request_o),
		.bios_protect_o (bios_protect_o),
		.bus_write_o    (bus_write_o),
		.mem_write_n_o  (mem_write_n_o)
	);

	initial begin
		clk_chipset = 1'b0;
		forever #5 clk_chipset = ~clk_chipset;
	end

	////////////////////////////////////////////////////////////////////////////
	// bus monitor
	////////////////////////////////////////////////////////////////////////////

	// sampled mid-cycle, where strobe and bus are stable
	always @(negedge clk_chipset) begin
		cycle = cycle + 1;
		if (reset) begin
			write_n_prev = 1'b1;
		end else begin
			if (write_n_prev && !mem_write_n_o) begin
				// falling edge marks the write
				obs_q.push_back(bus_write_o);
				if (last_fall >= 0 && (cycle - last_fall) < gap_min)
					gap_min = cycle - last_fall;
				last_fall = cycle;
				low_run   = 1;
			end else if (!write_n_prev && !mem_write_n_o) begin
				low_run = low_run + 1;
			end else if (!write_n_prev && mem_write_n_o) begin
				if (low_run < low_min)
					low_min = low_run;
				if (low_run > low_max)
					low_max = low_run;
			end
			write_n_prev = mem_write_n_o;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model and helpers
	////////////////////////////////////////////////////////////////////////////

	// BIOS images need offset below 64 KiB, XT-IDE wraps
	function automatic logic beat_hits(input ioctl_beat_t b);
		if (b.index == IMG_XTIDE)
			return 1'b1;
		return ((b.index == IMG_PCXT) || (b.index == IMG_TANDY)) && (b.offset < 25'h10000);
	endfunction

	// both windows are aligned, so the base supplies the upper bits
	function automatic bus_write_t expect_write(input ioctl_beat_t b);
		bus_write_t w;
		if (b.index == IMG_XTIDE)
			w.addr = {XTIDE_BASE[19:14], b.offset[13:0]};
		else
			w.addr = {BIOS_BASE[19:16], b.offset[15:0]};
		w.data  = b.data;
		w.tandy = (b.index == IMG_TANDY);
		return w;
	endfunction

	function automatic ioctl_beat_t make_beat(input logic [7:0] index,
	                                          input logic [24:0] offset_mask);
		ioctl_beat_t b;
		logic [31:0] r;
		r        = $random(seed);
		b.index  = index;
		b.offset = r[24:0] & offset_mask;
		r        = $random(seed);
		b.data   = r[7:0];
		return b;
	endfunction

	function automatic string format_write(input bus_write_t w);
		return $sformatf("addr=%05h data=%02h tandy=%0b", w.addr, w.data, w.tandy);
	endfunction

	task automatic next_cycle;
		@(posedge clk_chipset);
		#1;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic reset_stats;
		last_fall = -1;
		low_run   = 0;
		low_min   = 1 << 30;
		low_max   = 0;
		gap_min   = 1 << 30;
	endtask

	task automatic end_test(input string name);
		$display("test %s finished with %0d errors", name, errors - test_start);
		test_start = errors;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_write(input string name, input bus_write_t got,
	                           input bus_write_t exp_w);
		checks++;
		if (got !== exp_w) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %s got %s",
			         $time, name, format_write(exp_w), format_write(got));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp_b);
		checks++;
		if (got !== exp_b) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %0b got %0b", $time, name, exp_b, got);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp_n);
		checks++;
		if (got != exp_n) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %0d got %0d", $time, name, exp_n, got);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stream driving
	////////////////////////////////////////////////////////////////////////////

	// raise valid and log the write this beat should cause
	task automatic drive_beat(input ioctl_beat_t b);
		beat_i       = b;
		beat_valid_i = 1'b1;
		if (beat_hits(b))
			exp_q.push_back(expect_write(b));
	endtask

	// ready seen mid-cycle means the next edge takes the beat
	task automatic wait_accept;
		int waited;
		waited = 0;
		@(negedge clk_chipset);
		while (!beat_ready_o && waited < READY_TIMEOUT) begin
			@(negedge clk_chipset);
			waited++;
		end
		if (!beat_ready_o) begin
			abort_run($sformatf("timeout at %0t ns: beat_ready_o stayed low for %0d cycles",
			                    $time, waited));
		end else begin
			next_cycle();
			beat_valid_i = 1'b0;
		end
	endtask

	task automatic send_beat(input ioctl_beat_t b);
		drive_beat(b);
		wait_accept();
	endtask

	// wait for every expected strobe then compare in order
	task automatic wait_writes;
		int         waited;
		int         limit;
		bus_write_t got_w;
		bus_write_t exp_w;
		waited = 0;
		limit  = (exp_q.size() + 1) * (CYCLE_CYCLES + 8);
		while (obs_q.size() < exp_q.size() && waited < limit) begin
			@(posedge clk_chipset);
			waited++;
		end
		if (obs_q.size() < exp_q.size()) begin
			abort_run($sformatf("timeout at %0t ns: saw %0d of %0d bus writes",
			                    $time, obs_q.size(), exp_q.size()));
		end else begin
			// quiet period longer than one write cycle
			repeat (CYCLE_CYCLES + 4) @(posedge clk_chipset);
			#1;
			check_count("strobe count", obs_q.size(), exp_q.size());
			while (exp_q.size() > 0 && obs_q.size() > 0) begin
				got_w = obs_q.pop_front();
				exp_w = exp_q.pop_front();
				check_write("bus_write_o", got_w, exp_w);
			end
			exp_q.delete();
			obs_q.delete();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_after_reset;
		check_bit("bus_request_o", bus_request_o, 1'b0);
		check_bit("mem_write_n_o", mem_write_n_o, 1'b1);
		check_bit("bios_protect_o", bios_protect_o, 1'b1);
		check_bit("beat_ready_o", beat_ready_o, 1'b1);
		end_test("after_reset");
	endtask

	task automatic test_bios_bytes;
		for (int i = 0; i < 6; i++)
			send_beat(make_beat(i[0] ? IMG_TANDY : IMG_PCXT, 25'h0FFFF));
		wait_writes();
		end_test("bios_bytes");
	endtask

	task automatic test_xtide_bytes;
		// high offset bits wrap inside the 16 KiB window
		for (int i = 0; i < 4; i++)
			send_beat(make_beat(IMG_XTIDE, 25'h1FFFFFF));
		wait_writes();
		end_test("xtide_bytes");
	endtask

	task automatic test_discard;
		ioctl_beat_t b;
		send_beat(make_beat(8'd5, '1));
		b            = make_beat(IMG_PCXT, 25'h0FFFF);
		b.offset[16] = 1'b1;
		send_beat(b);
		b            = make_beat(IMG_TANDY, 25'h0FFFF);
		b.offset[24] = 1'b1;
		send_beat(b);
		send_beat(make_beat(IMG_PCXT, 25'h0FFFF));
		wait_writes();
		end_test("discard");
	endtask

	task automatic test_bus_grant;
		bus_granted_i = 1'b0;
		download_i    = 1'b0;
		next_cycle();
		check_bit("bus_request_o", bus_request_o, 1'b0);
		// request follows the download one cycle later, grant or not
		download_i = 1'b1;
		next_cycle();
		check_bit("bus_request_o", bus_request_o, 1'b1);
		// first byte parks in decode, second waits at the input
		send_beat(make_beat(IMG_PCXT, 25'h0FFFF));
		drive_beat(make_beat(IMG_TANDY, 25'h0FFFF));
		repeat (6) next_cycle();
		check_bit("beat_ready_o", beat_ready_o, 1'b0);
		check_bit("bios_protect_o", bios_protect_o, 1'b1);
		check_bit("mem_write_n_o", mem_write_n_o, 1'b1);
		check_count("strobes without grant", obs_q.size(), 0);
		bus_granted_i = 1'b1;
		wait_accept();
		send_beat(make_beat(IMG_XTIDE, '1));
		wait_writes();
		check_bit("bios_protect_o", bios_protect_o, 1'b0);
		// protect returns as soon as the grant goes
		bus_granted_i = 1'b0;
		@(negedge clk_chipset);
		check_bit("bios_protect_o", bios_protect_o, 1'b1);
		next_cycle();
		bus_granted_i = 1'b1;
		next_cycle();
		end_test("bus_grant");
	endtask

	task automatic test_strobe_shape;
		reset_stats();
		for (int i = 0; i < 5; i++)
			send_beat(make_beat(i[0] ? IMG_TANDY : IMG_PCXT, 25'h0FFFF));
		wait_writes();
		check_count("mem_write_n_o shortest low time", low_min, PULSE_CYCLES);
		check_count("mem_write_n_o longest low time", low_max, PULSE_CYCLES);
		checks++;
		if (gap_min < CYCLE_CYCLES) begin
			errors++;
			$display("write strobes fell only %0d cycles apart, need at least %0d",
			         gap_min, CYCLE_CYCLES);
		end
		end_test("strobe_shape");
	endtask

	initial begin
		seed         = 48;
		errors       = 0;
		checks       = 0;
		test_start   = 0;
		cycle        = 0;
		write_n_prev = 1'b1;
		reset_stats();
		reset         = 1'b1;
		download_i    = 1'b0;
		sdram_ready_i = 1'b0;
		bus_granted_i = 1'b0;
		beat_valid_i  = 1'b0;
		beat_i        = '0;
		repeat (16) @(posedge clk_chipset);
		#1;
		reset = 1'b0;
		next_cycle();
		test_after_reset();
		download_i    = 1'b1;
		sdram_ready_i = 1'b1;
		bus_granted_i = 1'b1;
		next_cycle();
		next_cycle();
		test_bios_bytes();
		test_xtide_bytes();
		test_discard();
		test_bus_grant();
		test_strobe_shape();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== write_strobe_timer.sv ====
// write stage; assumes WRITE_PULSE_CYCLES is at least 1 and below WRITE_CYCLE_CYCLES - 1
module write_strobe_timer
	import loader_pkg::*;
#(
	parameter int WRITE_PULSE_CYCLES = 21,
	parameter int WRITE_CYCLE_CYCLES = 41
) (
	input  logic       clk_chipset,
	input  logic       reset,
	input  logic       in_valid_i,
	input  bus_write_t in_i,
	output logic       in_ready_o,
	output bus_write_t bus_write_o,
	output logic       mem_write_n_o
);

	localparam int CNT_W = $clog2(WRITE_CYCLE_CYCLES + 1);

	// value on the bus between writes
	localparam bus_write_t BUS_IDLE = '{addr: '1, data: '1, tandy: 1'b0};

	logic             busy_q;
	logic [CNT_W-1:0] cnt_q;
	logic             write_n_q;
	logic             accept;
	bus_write_t       write_q;

	// one write at a time
	assign in_ready_o = ~busy_q;
	assign accept     = in_valid_i & ~busy_q;

	//////////////////////////////////////////////////////////////////////////
	// strobe sequencer
	//////////////////////////////////////////////////////////////////////////

	// cnt_q holds the cycles elapsed since acceptance
	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			busy_q    <= 1'b0;
			cnt_q     <= '0;
			write_n_q <= 1'b1;
			write_q   <= BUS_IDLE;
		end
		else if (accept) begin
			busy_q    <= 1'b1;
			cnt_q     <= '0;
			// address and data go out now, strobe follows next cycle
			write_q   <= in_i;
			write_n_q <= 1'b1;
		end
		else if (busy_q) begin
			cnt_q <= cnt_q + 1'b1;

			// low for exactly WRITE_PULSE_CYCLES cycles
			write_n_q <= ~(cnt_q < CNT_W'(WRITE_PULSE_CYCLES));

			// release the bus as the strobe rises
			if (cnt_q == CNT_W'(WRITE_PULSE_CYCLES))
				write_q <= BUS_IDLE;

			// recovery gap ends the write cycle
			if (cnt_q == CNT_W'(WRITE_CYCLE_CYCLES - 1))
				busy_q <= 1'b0;
		end
	end

	assign bus_write_o   = write_q;
	assign mem_write_n_o = write_n_q;

endmodule
